/* rtl/uce_config.svh */
`ifndef UCE_CONFIG_SVH
`define UCE_CONFIG_SVH

// physical address and payload sizes
`define UCE_PADDR_WIDTH 24
`define UCE_BLOCK_WIDTH 128
`define UCE_DWORD_WIDTH 64

// cache geometry
`define UCE_SETS  16
`define UCE_ASSOC 2

// outstanding memory transactions allowed at once
`define UCE_MEM_CREDITS 4

// derived widths
`define UCE_INDEX_WIDTH ($clog2(`UCE_SETS))
`define UCE_WAY_WIDTH ($clog2(`UCE_ASSOC))
`define UCE_BLOCK_OFFSET_WIDTH ($clog2(`UCE_BLOCK_WIDTH / 8))
`define UCE_TAG_WIDTH \
  (`UCE_PADDR_WIDTH - `UCE_INDEX_WIDTH - `UCE_BLOCK_OFFSET_WIDTH)

`endif

/* rtl/uce_pkg.sv */
`default_nettype none

`include "uce_config.svh"

package uce_pkg;

  typedef enum logic [1:0]
  {
    e_miss_load,
    e_miss_store,
    e_uc_load,
    e_uc_store
  } uce_req_type_e;

  // size is log2 of the byte count
  typedef struct packed
  {
    uce_req_type_e                msg_type;
    logic [`UCE_PADDR_WIDTH-1:0]  addr;
    logic [2:0]                   size;
    logic [`UCE_DWORD_WIDTH-1:0]  data;
    logic [`UCE_WAY_WIDTH-1:0]    repl_way;
    logic                         dirty;
  } uce_cache_req_s;

  typedef enum logic [1:0]
  {
    e_mem_rd,
    e_mem_wr,
    e_mem_uc_rd,
    e_mem_uc_wr
  } uce_mem_type_e;

  // same layout for commands and responses
  typedef struct packed
  {
    uce_mem_type_e                msg_type;
    logic [`UCE_PADDR_WIDTH-1:0]  addr;
    logic [2:0]                   size;
    logic [`UCE_WAY_WIDTH-1:0]    way_id;
    logic [`UCE_BLOCK_WIDTH-1:0]  data;
  } uce_mem_msg_s;

  typedef enum logic
  {
    e_tag_read,
    e_tag_set_tag
  } uce_tag_op_e;

  typedef struct packed
  {
    uce_tag_op_e                  opcode;
    logic [`UCE_INDEX_WIDTH-1:0]  index;
    logic [`UCE_WAY_WIDTH-1:0]    way_id;
    logic [`UCE_TAG_WIDTH-1:0]    tag;
  } uce_tag_mem_pkt_s;

  typedef enum logic [1:0]
  {
    e_data_read,
    e_data_write,
    e_data_uncached
  } uce_data_op_e;

  typedef struct packed
  {
    uce_data_op_e                 opcode;
    logic [`UCE_INDEX_WIDTH-1:0]  index;
    logic [`UCE_WAY_WIDTH-1:0]    way_id;
    logic [`UCE_BLOCK_WIDTH-1:0]  data;
  } uce_data_mem_pkt_s;

  // clears the dirty bit of one line
  typedef struct packed
  {
    logic [`UCE_INDEX_WIDTH-1:0]  index;
    logic [`UCE_WAY_WIDTH-1:0]    way_id;
  } uce_stat_mem_pkt_s;

  typedef logic [$clog2(`UCE_MEM_CREDITS + 1)-1:0] uce_credit_t;

endpackage

`default_nettype wire

/* rtl/uce_credit_tracker.sv */
`default_nettype none

`include "uce_config.svh"

module uce_credit_tracker
  (
    input  logic clk_i,
    input  logic reset_i,

    input  logic cmd_sent_i,
    input  logic resp_retired_i,

    output logic credit_avail_o,
    output logic credits_full_o,
    output logic credits_empty_o
  );

  uce_pkg::uce_credit_t count_r;

  // send and retire in one cycle cancel out
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      count_r <= '0;
    end
    else if (cmd_sent_i & ~resp_retired_i)
    begin
      count_r <= count_r + 1'b1;
    end
    else if (~cmd_sent_i & resp_retired_i)
    begin
      count_r <= count_r - 1'b1;
    end
  end

  assign credits_full_o  = (count_r == uce_pkg::uce_credit_t'(`UCE_MEM_CREDITS));
  assign credits_empty_o = (count_r == '0);
  assign credit_avail_o  = ~credits_full_o;

  a_no_overflow: assert property (@(posedge clk_i) disable iff (reset_i)
    credits_full_o |-> !cmd_sent_i);

  a_no_underflow: assert property (@(posedge clk_i) disable iff (reset_i)
    credits_empty_o |-> !resp_retired_i);

endmodule

`default_nettype wire

/* rtl/uce_fill_write.sv */
`default_nettype none

`include "uce_config.svh"

module uce_fill_write
  (
    input  logic                          clk_i,
    input  logic                          reset_i,

    input  uce_pkg::uce_mem_msg_s         mem_resp_i,
    input  logic                          mem_resp_v_i,
    output logic                          mem_resp_yumi_o,

    output uce_pkg::uce_tag_mem_pkt_s     tag_pkt_o,
    output logic                          tag_pkt_v_o,
    input  logic                          tag_pkt_yumi_i,
    output uce_pkg::uce_data_mem_pkt_s    data_pkt_o,
    output logic                          data_pkt_v_o,
    input  logic                          data_pkt_yumi_i,

    output logic                          fill_done_o
  );

  logic is_rd;
  logic is_uc_rd;
  logic is_store;
  logic tag_done_r;
  logic data_done_r;
  logic tag_ok;
  logic data_ok;
  logic load_retire;

  assign is_rd    = mem_resp_v_i & (mem_resp_i.msg_type == uce_pkg::e_mem_rd);
  assign is_uc_rd = mem_resp_v_i & (mem_resp_i.msg_type == uce_pkg::e_mem_uc_rd);
  assign is_store = mem_resp_v_i & ((mem_resp_i.msg_type == uce_pkg::e_mem_wr)
                                    | (mem_resp_i.msg_type == uce_pkg::e_mem_uc_wr));

  always_comb
  begin
    tag_pkt_o        = '0;
    tag_pkt_o.opcode = uce_pkg::e_tag_set_tag;
    tag_pkt_o.index  = mem_resp_i.addr[`UCE_BLOCK_OFFSET_WIDTH +: `UCE_INDEX_WIDTH];
    tag_pkt_o.way_id = mem_resp_i.way_id;
    tag_pkt_o.tag    = mem_resp_i.addr[`UCE_PADDR_WIDTH-1 -: `UCE_TAG_WIDTH];

    data_pkt_o = '0;
    if (is_uc_rd)
    begin
      // low dword copied into every slot of the block
      data_pkt_o.opcode = uce_pkg::e_data_uncached;
      data_pkt_o.data   = {(`UCE_BLOCK_WIDTH / `UCE_DWORD_WIDTH)
                           {mem_resp_i.data[`UCE_DWORD_WIDTH-1:0]}};
    end
    else
    begin
      data_pkt_o.opcode = uce_pkg::e_data_write;
      data_pkt_o.index  = tag_pkt_o.index;
      data_pkt_o.way_id = mem_resp_i.way_id;
      data_pkt_o.data   = mem_resp_i.data;
    end
  end

  assign tag_pkt_v_o  = is_rd & ~tag_done_r;
  assign data_pkt_v_o = (is_rd | is_uc_rd) & ~data_done_r;

  assign tag_ok  = tag_done_r | tag_pkt_yumi_i;
  assign data_ok = data_done_r | data_pkt_yumi_i;

  assign fill_done_o     = is_rd & tag_ok & data_ok;
  assign load_retire     = fill_done_o | (is_uc_rd & data_ok);
  assign mem_resp_yumi_o = is_store | load_retire;

  // remembers which packets the cache has already taken
  always_ff @(posedge clk_i)
  begin
    if (reset_i | load_retire)
    begin
      tag_done_r  <= 1'b0;
      data_done_r <= 1'b0;
    end
    else
    begin
      tag_done_r  <= tag_done_r | (tag_pkt_v_o & tag_pkt_yumi_i);
      data_done_r <= data_done_r | (data_pkt_v_o & data_pkt_yumi_i);
    end
  end

  a_tag_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    tag_pkt_v_o && !tag_pkt_yumi_i |=> tag_pkt_v_o && $stable(tag_pkt_o));

  a_data_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    data_pkt_v_o && !data_pkt_yumi_i |=> data_pkt_v_o && $stable(data_pkt_o));

endmodule

`default_nettype wire

/* rtl/uce_cmd_issue.sv */
`default_nettype none

`include "uce_config.svh"

module uce_cmd_issue
  (
    input  logic                              clk_i,
    input  logic                              reset_i,

    input  uce_pkg::uce_cache_req_s           cache_req_i,
    input  logic                              cache_req_v_i,
    output logic                              cache_req_ready_o,
    output logic                              cache_req_complete_o,

    input  logic                              credit_avail_i,
    input  logic                              credits_full_i,
    output logic                              cmd_sent_o,

    output uce_pkg::uce_mem_msg_s             mem_cmd_o,
    output logic                              mem_cmd_v_o,

    output uce_pkg::uce_tag_mem_pkt_s         evict_tag_pkt_o,
    output uce_pkg::uce_data_mem_pkt_s        evict_data_pkt_o,
    output uce_pkg::uce_stat_mem_pkt_s        evict_stat_pkt_o,
    // bit 0 tag, bit 1 data, bit 2 stat
    output logic [2:0]                        evict_v_o,
    input  logic                              tag_pkt_yumi_i,
    input  logic                              data_pkt_yumi_i,
    input  logic                              stat_pkt_yumi_i,
    input  logic [`UCE_TAG_WIDTH-1:0]         tag_mem_i,
    input  logic [`UCE_BLOCK_WIDTH-1:0]       data_mem_i,

    input  logic                              fill_done_i,
    input  logic                              uc_data_yumi_i
  );

  localparam logic [2:0] block_size_lp = 3'(`UCE_BLOCK_OFFSET_WIDTH);

  typedef enum logic [2:0]
  {
    e_ready,
    e_evict,
    e_send_read,
    e_wait_fill,
    e_wb_uc
  } state_e;

  state_e                          state_r;
  state_e                          state_n;
  uce_pkg::uce_cache_req_s         req_r;
  logic [2:0]                      evict_done_r;
  logic [2:0]                      evict_accept;
  logic                            tag_rd_r;
  logic                            data_rd_r;
  logic [`UCE_TAG_WIDTH-1:0]       victim_tag_r;
  logic [`UCE_BLOCK_WIDTH-1:0]     victim_data_r;
  logic [`UCE_INDEX_WIDTH-1:0]     req_index;
  logic                            req_uc_load;
  logic                            accept;

  assign req_index   = req_r.addr[`UCE_BLOCK_OFFSET_WIDTH +: `UCE_INDEX_WIDTH];
  assign req_uc_load = (req_r.msg_type == uce_pkg::e_uc_load);

  assign cache_req_ready_o = (state_r == e_ready) & ~credits_full_i;
  assign accept            = cache_req_v_i & cache_req_ready_o;

  // victim read and dirty clear, each channel drops once taken
  assign evict_v_o    = (state_r == e_evict) ? ~evict_done_r : 3'b000;
  assign evict_accept = evict_v_o & {stat_pkt_yumi_i, data_pkt_yumi_i, tag_pkt_yumi_i};

  always_comb
  begin
    evict_tag_pkt_o        = '0;
    evict_tag_pkt_o.opcode = uce_pkg::e_tag_read;
    evict_tag_pkt_o.index  = req_index;
    evict_tag_pkt_o.way_id = req_r.repl_way;

    evict_data_pkt_o        = '0;
    evict_data_pkt_o.opcode = uce_pkg::e_data_read;
    evict_data_pkt_o.index  = req_index;
    evict_data_pkt_o.way_id = req_r.repl_way;

    evict_stat_pkt_o.index  = req_index;
    evict_stat_pkt_o.way_id = req_r.repl_way;
  end

  always_comb
  begin
    state_n              = state_r;
    mem_cmd_o            = '0;
    mem_cmd_v_o          = 1'b0;
    cache_req_complete_o = 1'b0;

    case (state_r)
      e_ready:
      begin
        if (accept)
        begin
          if (cache_req_i.msg_type == uce_pkg::e_uc_store)
          begin
            // goes straight out, no completion
            mem_cmd_o.msg_type = uce_pkg::e_mem_uc_wr;
            mem_cmd_o.addr     = cache_req_i.addr;
            mem_cmd_o.size     = cache_req_i.size;
            mem_cmd_o.data     = `UCE_BLOCK_WIDTH'(cache_req_i.data);
            mem_cmd_v_o        = credit_avail_i;
          end
          else if (cache_req_i.msg_type != uce_pkg::e_uc_load && cache_req_i.dirty)
          begin
            state_n = e_evict;
          end
          else
          begin
            state_n = e_send_read;
          end
        end
      end
      e_evict:
      begin
        if ((evict_done_r | evict_accept) == 3'b111)
        begin
          state_n = e_send_read;
        end
      end
      e_send_read:
      begin
        if (req_uc_load)
        begin
          mem_cmd_o.msg_type = uce_pkg::e_mem_uc_rd;
          mem_cmd_o.addr     = req_r.addr;
          mem_cmd_o.size     = req_r.size;
        end
        else
        begin
          mem_cmd_o.msg_type = uce_pkg::e_mem_rd;
          mem_cmd_o.addr     = {req_r.addr[`UCE_PADDR_WIDTH-1:`UCE_BLOCK_OFFSET_WIDTH],
                                {`UCE_BLOCK_OFFSET_WIDTH{1'b0}}};
          mem_cmd_o.size     = block_size_lp;
          mem_cmd_o.way_id   = req_r.repl_way;
        end
        mem_cmd_v_o = credit_avail_i;
        if (credit_avail_i)
        begin
          state_n = req_uc_load ? e_wb_uc : e_wait_fill;
        end
      end
      e_wait_fill:
      begin
        if (fill_done_i)
        begin
          cache_req_complete_o = ~req_r.dirty;
          state_n              = req_r.dirty ? e_wb_uc : e_ready;
        end
      end
      e_wb_uc:
      begin
        if (req_uc_load)
        begin
          // uncached data handed over by the fill writer
          cache_req_complete_o = uc_data_yumi_i;
          if (uc_data_yumi_i)
          begin
            state_n = e_ready;
          end
        end
        else
        begin
          mem_cmd_o.msg_type   = uce_pkg::e_mem_wr;
          mem_cmd_o.addr       = {victim_tag_r, req_index, {`UCE_BLOCK_OFFSET_WIDTH{1'b0}}};
          mem_cmd_o.size       = block_size_lp;
          mem_cmd_o.way_id     = req_r.repl_way;
          mem_cmd_o.data       = victim_data_r;
          mem_cmd_v_o          = credit_avail_i;
          cache_req_complete_o = credit_avail_i;
          if (credit_avail_i)
          begin
            state_n = e_ready;
          end
        end
      end
      default:
      begin
        state_n = e_ready;
      end
    endcase
  end

  assign cmd_sent_o = mem_cmd_v_o;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r      <= e_ready;
      evict_done_r <= 3'b000;
      tag_rd_r     <= 1'b0;
      data_rd_r    <= 1'b0;
    end
    else
    begin
      state_r      <= state_n;
      evict_done_r <= (state_n == e_evict) ? (evict_done_r | evict_accept) : 3'b000;
      tag_rd_r     <= evict_accept[0];
      data_rd_r    <= evict_accept[1];
    end
  end

  // read results show up one cycle after the yumi
  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      req_r <= cache_req_i;
    end
    if (tag_rd_r)
    begin
      victim_tag_r <= tag_mem_i;
    end
    if (data_rd_r)
    begin
      victim_data_r <= data_mem_i;
    end
  end

endmodule

`default_nettype wire

/* rtl/uce_top.sv */
`default_nettype none

`include "uce_config.svh"

module uce_top
  (
    input  logic                              clk_i,
    input  logic                              reset_i,

    input  uce_pkg::uce_cache_req_s           cache_req_i,
    input  logic                              cache_req_v_i,
    output logic                              cache_req_ready_o,
    output logic                              cache_req_complete_o,

    output uce_pkg::uce_tag_mem_pkt_s         tag_mem_pkt_o,
    output logic                              tag_mem_pkt_v_o,
    input  logic                              tag_mem_pkt_yumi_i,
    input  logic [`UCE_TAG_WIDTH-1:0]         tag_mem_i,

    output uce_pkg::uce_data_mem_pkt_s        data_mem_pkt_o,
    output logic                              data_mem_pkt_v_o,
    input  logic                              data_mem_pkt_yumi_i,
    input  logic [`UCE_BLOCK_WIDTH-1:0]       data_mem_i,

    output uce_pkg::uce_stat_mem_pkt_s        stat_mem_pkt_o,
    output logic                              stat_mem_pkt_v_o,
    input  logic                              stat_mem_pkt_yumi_i,

    output logic                              credits_full_o,
    output logic                              credits_empty_o,

    output uce_pkg::uce_mem_msg_s             mem_cmd_o,
    output logic                              mem_cmd_v_o,

    input  uce_pkg::uce_mem_msg_s             mem_resp_i,
    input  logic                              mem_resp_v_i,
    output logic                              mem_resp_yumi_o
  );

  uce_pkg::uce_tag_mem_pkt_s   evict_tag_pkt;
  uce_pkg::uce_data_mem_pkt_s  evict_data_pkt;
  uce_pkg::uce_tag_mem_pkt_s   fill_tag_pkt;
  uce_pkg::uce_data_mem_pkt_s  fill_data_pkt;
  logic [2:0]                  evict_v;
  logic                        fill_tag_v;
  logic                        fill_data_v;
  logic                        fill_tag_yumi;
  logic                        fill_data_yumi;
  logic                        uc_data_yumi;
  logic                        cmd_sent;
  logic                        fill_done;
  logic                        credit_avail;

  uce_cmd_issue issue
    (
      .clk_i                (clk_i),
      .reset_i              (reset_i),
      .cache_req_i          (cache_req_i),
      .cache_req_v_i        (cache_req_v_i),
      .cache_req_ready_o    (cache_req_ready_o),
      .cache_req_complete_o (cache_req_complete_o),
      .credit_avail_i       (credit_avail),
      .credits_full_i       (credits_full_o),
      .cmd_sent_o           (cmd_sent),
      .mem_cmd_o            (mem_cmd_o),
      .mem_cmd_v_o          (mem_cmd_v_o),
      .evict_tag_pkt_o      (evict_tag_pkt),
      .evict_data_pkt_o     (evict_data_pkt),
      .evict_stat_pkt_o     (stat_mem_pkt_o),
      .evict_v_o            (evict_v),
      .tag_pkt_yumi_i       (tag_mem_pkt_yumi_i),
      .data_pkt_yumi_i      (data_mem_pkt_yumi_i),
      .stat_pkt_yumi_i      (stat_mem_pkt_yumi_i),
      .tag_mem_i            (tag_mem_i),
      .data_mem_i           (data_mem_i),
      .fill_done_i          (fill_done),
      .uc_data_yumi_i       (uc_data_yumi)
    );

  uce_fill_write fill
    (
      .clk_i           (clk_i),
      .reset_i         (reset_i),
      .mem_resp_i      (mem_resp_i),
      .mem_resp_v_i    (mem_resp_v_i),
      .mem_resp_yumi_o (mem_resp_yumi_o),
      .tag_pkt_o       (fill_tag_pkt),
      .tag_pkt_v_o     (fill_tag_v),
      .tag_pkt_yumi_i  (fill_tag_yumi),
      .data_pkt_o      (fill_data_pkt),
      .data_pkt_v_o    (fill_data_v),
      .data_pkt_yumi_i (fill_data_yumi),
      .fill_done_o     (fill_done)
    );

  uce_credit_tracker credits
    (
      .clk_i           (clk_i),
      .reset_i         (reset_i),
      .cmd_sent_i      (cmd_sent),
      .resp_retired_i  (mem_resp_yumi_o),
      .credit_avail_o  (credit_avail),
      .credits_full_o  (credits_full_o),
      .credits_empty_o (credits_empty_o)
    );

  // evict traffic wins each channel over fill traffic
  assign tag_mem_pkt_o    = evict_v[0] ? evict_tag_pkt : fill_tag_pkt;
  assign tag_mem_pkt_v_o  = evict_v[0] | fill_tag_v;
  assign data_mem_pkt_o   = evict_v[1] ? evict_data_pkt : fill_data_pkt;
  assign data_mem_pkt_v_o = evict_v[1] | fill_data_v;
  assign stat_mem_pkt_v_o = evict_v[2];

  assign fill_tag_yumi  = tag_mem_pkt_yumi_i & ~evict_v[0];
  assign fill_data_yumi = data_mem_pkt_yumi_i & ~evict_v[1];
  assign uc_data_yumi   = fill_data_yumi & (fill_data_pkt.opcode == uce_pkg::e_data_uncached);

endmodule

`default_nettype wire

/* sim/tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen
  (
    output logic clk_o,
    output logic reset_o
  );

  timeunit 1ns;
  timeprecision 1ps;

  initial
  begin
    clk_o   = 1'b0;
    reset_o = 1'b1;
    repeat (4) @(posedge clk_o);
    #2 reset_o = 1'b0;
  end

  always #10 clk_o = ~clk_o;

endmodule

`default_nettype wire

/* sim/tb_uce.sv */
`default_nettype none

`include "uce_config.svh"

module tb_uce;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int iw_lp = `UCE_INDEX_WIDTH;
  localparam int ow_lp = `UCE_BLOCK_OFFSET_WIDTH;
  localparam int tw_lp = `UCE_TAG_WIDTH;
  localparam int lines_lp = `UCE_SETS * `UCE_ASSOC;
  localparam int timeout_lp = 200;
  localparam logic [2:0] blk_size_lp = 3'($clog2(`UCE_BLOCK_WIDTH / 8));

  typedef struct packed
  {
    uce_pkg::uce_cache_req_s req;
    logic                    exp_complete;
    // complete must coincide with {cmd valid, data yumi, tag yumi}
    logic [2:0]              cpl_mask;
  } row_s;

  logic clk_i;
  logic reset_i;
  uce_pkg::uce_cache_req_s cache_req_i;
  logic cache_req_v_i, cache_req_ready_o, cache_req_complete_o;
  uce_pkg::uce_tag_mem_pkt_s tag_pkt;
  uce_pkg::uce_data_mem_pkt_s data_pkt;
  uce_pkg::uce_stat_mem_pkt_s stat_pkt;
  logic tag_v, data_v, stat_v, tag_yumi, data_yumi, stat_yumi;
  logic tag_yumi_n, data_yumi_n, stat_yumi_n;
  logic [tw_lp-1:0] tag_mem, tag_mem_n;
  logic [`UCE_BLOCK_WIDTH-1:0] data_mem, data_mem_n;
  logic credits_full_o, credits_empty_o;
  uce_pkg::uce_mem_msg_s mem_cmd_o, mem_resp_i;
  logic mem_cmd_v_o, mem_resp_v_i, mem_resp_yumi_o;

  logic [tw_lp-1:0] tag_arr [lines_lp];
  logic [`UCE_BLOCK_WIDTH-1:0] data_arr [lines_lp];
  uce_pkg::uce_mem_msg_s pend_q[$], got_cmd_q[$], exp_cmd_q[$];
  uce_pkg::uce_tag_mem_pkt_s got_tag_q[$], exp_tag_q[$];
  uce_pkg::uce_data_mem_pkt_s got_data_q[$], exp_data_q[$];
  uce_pkg::uce_stat_mem_pkt_s got_stat_q[$], exp_stat_q[$];
  logic [2:0] compl_q[$];
  logic hold;
  int release_n;
  row_s stim [5];

  tb_clock_gen clock_gen (.clk_o(clk_i), .reset_o(reset_i));

  uce_top DUT
    (
      .clk_i(clk_i), .reset_i(reset_i),
      .cache_req_i(cache_req_i), .cache_req_v_i(cache_req_v_i),
      .cache_req_ready_o(cache_req_ready_o), .cache_req_complete_o(cache_req_complete_o),
      .tag_mem_pkt_o(tag_pkt), .tag_mem_pkt_v_o(tag_v),
      .tag_mem_pkt_yumi_i(tag_yumi), .tag_mem_i(tag_mem),
      .data_mem_pkt_o(data_pkt), .data_mem_pkt_v_o(data_v),
      .data_mem_pkt_yumi_i(data_yumi), .data_mem_i(data_mem),
      .stat_mem_pkt_o(stat_pkt), .stat_mem_pkt_v_o(stat_v), .stat_mem_pkt_yumi_i(stat_yumi),
      .credits_full_o(credits_full_o), .credits_empty_o(credits_empty_o),
      .mem_cmd_o(mem_cmd_o), .mem_cmd_v_o(mem_cmd_v_o),
      .mem_resp_i(mem_resp_i), .mem_resp_v_i(mem_resp_v_i), .mem_resp_yumi_o(mem_resp_yumi_o)
    );

  // every 32-bit word of a memory block carries its full address
  function automatic logic [`UCE_BLOCK_WIDTH-1:0] mem_pattern(logic [`UCE_PADDR_WIDTH-1:0] a);
    return {a, 8'ha5, a, 8'h3c, a, 8'he1, a, 8'h0f};
  endfunction

  // reads come back with the memory pattern of their address
  function automatic uce_pkg::uce_mem_msg_s mem_response(uce_pkg::uce_mem_msg_s cmd);
    uce_pkg::uce_mem_msg_s resp;
    resp = cmd;
    if (cmd.msg_type inside {uce_pkg::e_mem_rd, uce_pkg::e_mem_uc_rd})
    begin
      resp.data = mem_pattern(cmd.addr);
    end
    return resp;
  endfunction

  function automatic row_s row(uce_pkg::uce_req_type_e t, logic [`UCE_PADDR_WIDTH-1:0] a,
                               logic [63:0] d, logic w, logic dirty, logic cpl, logic [2:0] m);
    row_s r;
    r = '0;
    r.req.msg_type = t;
    r.req.addr = a;
    r.req.size = 3'd3;
    r.req.data = d;
    r.req.repl_way = w;
    r.req.dirty = dirty;
    r.exp_complete = cpl;
    r.cpl_mask = m;
    return r;
  endfunction

  task automatic fail_now(string what);
    $display("%s", what);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic check_mem_msg(string name, uce_pkg::uce_mem_msg_s got,
                               uce_pkg::uce_mem_msg_s exp);
    if (got !== exp)
    begin
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      fail_now("memory command mismatch");
    end
  endtask

  task automatic check_tag_pkt(string name, uce_pkg::uce_tag_mem_pkt_s got,
                               uce_pkg::uce_tag_mem_pkt_s exp);
    if (got !== exp)
    begin
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      fail_now("tag packet mismatch");
    end
  endtask

  task automatic check_data_pkt(string name, uce_pkg::uce_data_mem_pkt_s got,
                                uce_pkg::uce_data_mem_pkt_s exp);
    if (got !== exp)
    begin
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      fail_now("data packet mismatch");
    end
  endtask

  task automatic check_stat_pkt(string name, uce_pkg::uce_stat_mem_pkt_s got,
                                uce_pkg::uce_stat_mem_pkt_s exp);
    if (got !== exp)
    begin
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      fail_now("dirty-clear packet mismatch");
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp)
    begin
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      fail_now("flag mismatch");
    end
  endtask

  task automatic check_count(string name, int got, int exp);
    if (got != exp)
    begin
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      fail_now("wrong number of transfers");
    end
  endtask

  // cache and memory model samples late in the cycle
  always @(negedge clk_i)
  begin
    if (!reset_i)
    begin
      if (mem_cmd_v_o)
      begin
        got_cmd_q.push_back(mem_cmd_o);
        pend_q.push_back(mem_response(mem_cmd_o));
      end
      if (mem_resp_v_i && mem_resp_yumi_o)
      begin
        void'(pend_q.pop_front());
        if (hold && release_n > 0)
        begin
          release_n--;
        end
      end
      if (tag_v && tag_yumi)
      begin
        got_tag_q.push_back(tag_pkt);
        if (tag_pkt.opcode == uce_pkg::e_tag_set_tag)
          tag_arr[{tag_pkt.index, tag_pkt.way_id}] = tag_pkt.tag;
        else
          tag_mem_n = tag_arr[{tag_pkt.index, tag_pkt.way_id}];
      end
      if (data_v && data_yumi)
      begin
        got_data_q.push_back(data_pkt);
        if (data_pkt.opcode == uce_pkg::e_data_write)
          data_arr[{data_pkt.index, data_pkt.way_id}] = data_pkt.data;
        else if (data_pkt.opcode == uce_pkg::e_data_read)
          data_mem_n = data_arr[{data_pkt.index, data_pkt.way_id}];
      end
      if (stat_v && stat_yumi)
        got_stat_q.push_back(stat_pkt);
      if (cache_req_complete_o)
        compl_q.push_back({mem_cmd_v_o, data_yumi & data_v, tag_yumi & tag_v});
      tag_yumi_n  = tag_v && !tag_yumi && ($urandom % 2 == 0);
      data_yumi_n = data_v && !data_yumi && ($urandom % 2 == 0);
      stat_yumi_n = stat_v && !stat_yumi && ($urandom % 2 == 0);
    end
  end

  always @(posedge clk_i)
  begin
    #2;
    tag_yumi = tag_yumi_n;
    data_yumi = data_yumi_n;
    stat_yumi = stat_yumi_n;
    tag_mem = tag_mem_n;
    data_mem = data_mem_n;
    mem_resp_v_i = (pend_q.size() > 0) && (!hold || release_n > 0);
    mem_resp_i = (pend_q.size() > 0) ? pend_q[0] : '0;
  end

  task automatic clear_queues();
    got_cmd_q.delete();
    got_tag_q.delete();
    got_data_q.delete();
    got_stat_q.delete();
    compl_q.delete();
    exp_cmd_q.delete();
    exp_tag_q.delete();
    exp_data_q.delete();
    exp_stat_q.delete();
  endtask

  task automatic build_expect(uce_pkg::uce_cache_req_s r);
    uce_pkg::uce_mem_msg_s c;
    uce_pkg::uce_tag_mem_pkt_s t;
    uce_pkg::uce_data_mem_pkt_s d;
    uce_pkg::uce_stat_mem_pkt_s s;
    logic [iw_lp-1:0] idx;
    logic [`UCE_PADDR_WIDTH-1:0] blk;
    logic [`UCE_BLOCK_WIDTH-1:0] pattern;
    idx = r.addr[ow_lp +: iw_lp];
    blk = {r.addr[`UCE_PADDR_WIDTH-1:ow_lp], {ow_lp{1'b0}}};
    c = '0;
    t = '0;
    d = '0;
    if (r.msg_type == uce_pkg::e_uc_store || r.msg_type == uce_pkg::e_uc_load)
    begin
      c.msg_type = (r.msg_type == uce_pkg::e_uc_store) ? uce_pkg::e_mem_uc_wr
                                                       : uce_pkg::e_mem_uc_rd;
      c.addr = r.addr;
      c.size = r.size;
      c.data = (r.msg_type == uce_pkg::e_uc_store) ? 128'(r.data) : '0;
      exp_cmd_q.push_back(c);
      if (r.msg_type == uce_pkg::e_uc_load)
      begin
        pattern = mem_pattern(r.addr);
        d.opcode = uce_pkg::e_data_uncached;
        d.data = {2{pattern[63:0]}};
        exp_data_q.push_back(d);
      end
      return;
    end
    if (r.dirty)
    begin
      t.opcode = uce_pkg::e_tag_read;
      t.index = idx;
      t.way_id = r.repl_way;
      exp_tag_q.push_back(t);
      d.opcode = uce_pkg::e_data_read;
      d.index = idx;
      d.way_id = r.repl_way;
      exp_data_q.push_back(d);
      s.index = idx;
      s.way_id = r.repl_way;
      exp_stat_q.push_back(s);
    end
    c.msg_type = uce_pkg::e_mem_rd;
    c.addr = blk;
    c.size = blk_size_lp;
    c.way_id = r.repl_way;
    exp_cmd_q.push_back(c);
    t.opcode = uce_pkg::e_tag_set_tag;
    t.index = idx;
    t.way_id = r.repl_way;
    t.tag = r.addr[`UCE_PADDR_WIDTH-1 -: tw_lp];
    exp_tag_q.push_back(t);
    d.opcode = uce_pkg::e_data_write;
    d.index = idx;
    d.way_id = r.repl_way;
    d.data = mem_pattern(blk);
    exp_data_q.push_back(d);
    if (r.dirty)
    begin
      // victim as the cache model holds it before the fill
      c.msg_type = uce_pkg::e_mem_wr;
      c.addr = {tag_arr[{idx, r.repl_way}], idx, {ow_lp{1'b0}}};
      c.data = data_arr[{idx, r.repl_way}];
      exp_cmd_q.push_back(c);
    end
  endtask

  task automatic apply_req(uce_pkg::uce_cache_req_s r);
    int n;
    n = 0;
    @(negedge clk_i);
    while (!cache_req_ready_o)
    begin
      @(negedge clk_i);
      n++;
      if (n > timeout_lp)
        fail_now("timeout waiting for request ready");
    end
    @(posedge clk_i);
    #2;
    cache_req_i = r;
    cache_req_v_i = 1'b1;
    @(negedge clk_i);
    check_flag("cache_req_ready_o", cache_req_ready_o, 1'b1);
    @(posedge clk_i);
    #2 cache_req_v_i = 1'b0;
  endtask

  task automatic wait_idle(logic need_complete);
    int n;
    n = 0;
    while ((need_complete && compl_q.size() == 0) || !credits_empty_o || pend_q.size() != 0
           || got_cmd_q.size() < exp_cmd_q.size())
    begin
      @(negedge clk_i);
      n++;
      if (n > timeout_lp)
        fail_now("timeout waiting for the request to finish");
    end
  endtask

  initial
  begin
    int n;
    row_s store_row;
    cache_req_i = '0;
    cache_req_v_i = 1'b0;
    {tag_yumi, data_yumi, stat_yumi} = '0;
    {tag_yumi_n, data_yumi_n, stat_yumi_n} = '0;
    tag_mem = '0;
    tag_mem_n = '0;
    data_mem = '0;
    data_mem_n = '0;
    mem_resp_i = '0;
    mem_resp_v_i = 1'b0;
    hold = 1'b0;
    release_n = 0;
    void'($urandom(32'hd6));
    for (int k = 0; k < lines_lp; k++)
    begin
      tag_arr[k] = 16'h8000 ^ 16'(k * 16'h0307);
      data_arr[k] = {4{16'hbeef ^ 16'(k), 16'(k * 3 + 1)}};
    end
    stim[0] = row(uce_pkg::e_uc_store, 24'h012345, 64'hdeadbeef_01234567,
                  1'b0, 1'b0, 1'b0, 3'b000);
    stim[1] = row(uce_pkg::e_uc_load, 24'h004568, 64'h0, 1'b0, 1'b0, 1'b1, 3'b010);
    stim[2] = row(uce_pkg::e_miss_load, 24'h123456, 64'h0, 1'b1, 1'b0, 1'b1, 3'b011);
    stim[3] = row(uce_pkg::e_miss_store, 24'h2345a8, 64'h0, 1'b0, 1'b1, 1'b1, 3'b100);
    stim[4] = row(uce_pkg::e_miss_load, 24'h0abc74, 64'h0, 1'b1, 1'b1, 1'b1, 3'b100);

    n = 0;
    @(negedge clk_i);
    while (reset_i)
    begin
      @(negedge clk_i);
      n++;
      if (n > timeout_lp)
        fail_now("reset never released");
    end
    check_flag("tag_mem_pkt_v_o", tag_v, 1'b0);
    check_flag("data_mem_pkt_v_o", data_v, 1'b0);
    check_flag("stat_mem_pkt_v_o", stat_v, 1'b0);
    check_flag("mem_cmd_v_o", mem_cmd_v_o, 1'b0);
    check_flag("cache_req_complete_o", cache_req_complete_o, 1'b0);
    check_flag("mem_resp_yumi_o", mem_resp_yumi_o, 1'b0);
    check_flag("credits_empty_o", credits_empty_o, 1'b1);
    check_flag("cache_req_ready_o", cache_req_ready_o, 1'b1);

    for (int i = 0; i < 5; i++)
    begin
      clear_queues();
      build_expect(stim[i].req);
      apply_req(stim[i].req);
      wait_idle(stim[i].exp_complete);
      check_count("mem_cmd_o count", got_cmd_q.size(), exp_cmd_q.size());
      check_count("tag_mem_pkt_o count", got_tag_q.size(), exp_tag_q.size());
      check_count("data_mem_pkt_o count", got_data_q.size(), exp_data_q.size());
      check_count("stat_mem_pkt_o count", got_stat_q.size(), exp_stat_q.size());
      check_count("cache_req_complete_o count", compl_q.size(), int'(stim[i].exp_complete));
      foreach (exp_cmd_q[j]) check_mem_msg("mem_cmd_o", got_cmd_q[j], exp_cmd_q[j]);
      foreach (exp_tag_q[j]) check_tag_pkt("tag_mem_pkt_o", got_tag_q[j], exp_tag_q[j]);
      foreach (exp_data_q[j]) check_data_pkt("data_mem_pkt_o", got_data_q[j], exp_data_q[j]);
      foreach (exp_stat_q[j]) check_stat_pkt("stat_mem_pkt_o", got_stat_q[j], exp_stat_q[j]);
      if (stim[i].exp_complete)
        check_flag("cache_req_complete_o timing", |(compl_q[0] & stim[i].cpl_mask), 1'b1);
    end

    // credit limit with responses held back
    clear_queues();
    hold = 1'b1;
    for (int k = 0; k < `UCE_MEM_CREDITS; k++)
    begin
      store_row = row(uce_pkg::e_uc_store, 24'h300000 + 24'(k * 8), 64'(k), 1'b0, 1'b0,
                      1'b0, 3'b000);
      apply_req(store_row.req);
    end
    @(negedge clk_i);
    check_flag("credits_full_o", credits_full_o, 1'b1);
    check_flag("cache_req_ready_o", cache_req_ready_o, 1'b0);
    release_n = 1;
    n = 0;
    while (!cache_req_ready_o)
    begin
      @(negedge clk_i);
      n++;
      if (n > timeout_lp)
        fail_now("ready not restored after releasing one response");
    end
    check_flag("credits_full_o", credits_full_o, 1'b0);
    hold = 1'b0;
    n = 0;
    while (!credits_empty_o)
    begin
      @(negedge clk_i);
      n++;
      if (n > timeout_lp)
        fail_now("credits never returned to empty");
    end
    check_count("mem_cmd_o count", got_cmd_q.size(), `UCE_MEM_CREDITS);
    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+rtl
rtl/uce_pkg.sv
rtl/uce_credit_tracker.sv
rtl/uce_fill_write.sv
rtl/uce_cmd_issue.sv
rtl/uce_top.sv
sim/tb_clock_gen.sv
sim/tb_uce.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_uce
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= verilog.f
VFLAGS    ?= --binary --timing --assert

SRCS := $(filter-out +incdir+%,$(shell cat $(FILELIST))) rtl/uce_config.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then exit 1; fi
	@grep -q '\*\*\* PASSED \*\*\*' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
